// ==== Bender.yml ====
package:
  name: master_trig_l2

sources:
  # packages come first, then the design from the leaves up to the top level.
  - files:
      - design/trig_cfg_pkg.sv
      - design/trig_types_pkg.sv
      - design/master_trig_uram.sv
      - design/l2_readout_ctrl.sv
      - design/l2_trig_combiner.sv
      - design/master_trig_l2.sv

  # testbench, only for simulation.
  - target: simulation
    files:
      - sim/tb_master_trig_l2.sv

// ==== design/l2_readout_ctrl.sv ====
`timescale 1ns/100ps
// readout sequencer for both trigger stores.
// a start strobe turns into a read command and then a clear command to the same slot.
// both stores see the same command, so the two halves always stay in lockstep.
module l2_readout_ctrl (
    input  logic                              clk_i,
    input  logic                              reset_i,
    input  logic                              start_i,
    input  logic [trig_cfg_pkg::ADDR_W-1:0]   rd_addr_i,
    output logic                              busy_o,
    output trig_types_pkg::store_rd_t         rd_o,
    output logic [trig_cfg_pkg::ADDR_W-1:0]   addr_o,
    output logic                              issued_o
);

    import trig_cfg_pkg::*;
    import trig_types_pkg::*;

    readout_state_e    state_q;
    readout_state_e    state_d;

    // slot address captured with the start strobe.
    logic [ADDR_W-1:0] addr_q;

    // registered port-B command and the marker of its read cycle.
    store_rd_t         rd_q;
    logic              issued_q;

    // the sequence always runs to completion because nothing can hold it.
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (start_i) begin
                    state_d = READ;
                end
            end
            READ: begin
                state_d = CLEAR;
            end
            CLEAR: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // only a strobe taken in IDLE loads the address.
    // strobes during a sequence are dropped here and never reach the stores.
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && start_i) begin
            addr_q <= rd_addr_i;
        end
    end

    // the command goes out one cycle after the state that asks for it.
    // phase and address follow the state and the latched slot on every edge.
    // the stores look at them only while rd_en is high.
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rd_q.rd_en <= 1'b0;
            issued_q   <= 1'b0;
        end else begin
            rd_q.rd_en <= (state_q == READ) || (state_q == CLEAR);
            issued_q   <= (state_q == READ);
        end
        rd_q.rd_phase <= (state_q == CLEAR);
        rd_q.raddr    <= addr_q;
    end

    assign busy_o   = (state_q != IDLE);
    assign rd_o     = rd_q;
    // the address travels with the read marker, so the combiner can tag its result.
    assign addr_o   = rd_q.raddr;
    assign issued_o = issued_q;

endmodule

// ==== design/l2_trig_combiner.sv ====
`timescale 1ns/100ps
// L2 combiner for the two halves.
// it lines the readout marker up with the store data, applies the lane mask,
// counts the surviving triggers and registers one result word.
module l2_trig_combiner (
    input  logic                                 clk_i,
    input  logic                                 reset_i,
    input  logic                                 issued_i,
    input  logic [trig_cfg_pkg::ADDR_W-1:0]      addr_i,
    input  trig_types_pkg::store_dout_t          dout_a_i,
    input  trig_types_pkg::store_dout_t          dout_b_i,
    // low half masks side A, high half masks side B.
    input  logic [2*trig_cfg_pkg::NUM_LANES-1:0] mask_i,
    input  logic [trig_cfg_pkg::CNT_W-1:0]       threshold_i,
    output trig_types_pkg::l2_result_t           result_o
);

    import trig_cfg_pkg::*;
    import trig_types_pkg::*;

    // marker and address delayed by the store read latency.
    logic                 issued_q;
    logic [ADDR_W-1:0]    addr_q;

    // masked view of both halves.
    logic [NUM_LANES-1:0] trig_a_m;
    logic [NUM_LANES-1:0] trig_b_m;
    logic [META_W-1:0]    meta_a_m;
    logic [META_W-1:0]    meta_b_m;
    logic [CNT_W-1:0]     hit_count;

    l2_result_t           result_q;

    // zero the metadata byte of every lane that is masked off.
    function automatic logic [META_W-1:0] mask_meta(
        input logic [META_W-1:0]    meta,
        input logic [NUM_LANES-1:0] lane_en
    );
        logic [META_W-1:0] masked;
        for (int l = 0; l < NUM_LANES; l++) begin
            masked[l*LANE_W +: LANE_W] = lane_en[l] ? meta[l*LANE_W +: LANE_W] : '0;
        end
        return masked;
    endfunction

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            issued_q <= 1'b0;
        end else begin
            issued_q <= issued_i;
        end
        addr_q <= addr_i;
    end

    // the mask is applied here, at the L2 input, since the stores keep every lane.
    always_comb begin
        trig_a_m = dout_a_i.trigger & mask_i[NUM_LANES-1:0];
        trig_b_m = dout_b_i.trigger & mask_i[2*NUM_LANES-1:NUM_LANES];
        meta_a_m = mask_meta(dout_a_i.metadata, mask_i[NUM_LANES-1:0]);
        meta_b_m = mask_meta(dout_b_i.metadata, mask_i[2*NUM_LANES-1:NUM_LANES]);
    end

    // population count over all sixteen masked trigger bits.
    always_comb begin
        hit_count = '0;
        for (int l = 0; l < NUM_LANES; l++) begin
            hit_count = hit_count + CNT_W'(trig_a_m[l]) + CNT_W'(trig_b_m[l]);
        end
    end

    // valid is a single pulse per readout.
    // the rest of the word holds until the next readout replaces it.
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            result_q.valid <= 1'b0;
        end else begin
            result_q.valid <= issued_q;
        end
        if (issued_q) begin
            result_q.addr      <= addr_q;
            result_q.trig_a    <= trig_a_m;
            result_q.trig_b    <= trig_b_m;
            result_q.meta_a    <= meta_a_m;
            result_q.meta_b    <= meta_b_m;
            result_q.hit_count <= hit_count;
            // a threshold of zero accepts even an empty slot.
            result_q.accept    <= (hit_count >= threshold_i);
        end
    end

    assign result_o = result_q;

endmodule

// ==== design/master_trig_l2.sv ====
`timescale 1ns/100ps
// readout half of the master trigger process.
// two metadata stores, one per detector half, are read and cleared in lockstep,
// and the L2 combiner merges what they return into one accept decision.
module master_trig_l2 (
    input  logic                                 clk_i,
    input  logic                                 reset_i,
    // port-A writes for half A and half B.
    input  trig_types_pkg::trig_wr_t             wr_a_i,
    input  trig_types_pkg::trig_wr_t             wr_b_i,
    // one-cycle strobe that starts a readout of rd_addr_i.
    input  logic                                 start_i,
    input  logic [trig_cfg_pkg::ADDR_W-1:0]      rd_addr_i,
    input  logic [2*trig_cfg_pkg::NUM_LANES-1:0] mask_i,
    input  logic [trig_cfg_pkg::CNT_W-1:0]       threshold_i,
    output logic                                 busy_o,
    output trig_types_pkg::l2_result_t           result_o
);

    import trig_cfg_pkg::*;
    import trig_types_pkg::*;

    // shared port-B command for both stores.
    store_rd_t         rd_cmd;
    logic [ADDR_W-1:0] rd_addr_q;
    logic              issued;

    // raw store words, still unmasked.
    store_dout_t       dout_a;
    store_dout_t       dout_b;

    master_trig_uram u_store_a (
        .clk_i  (clk_i),
        .wr_i   (wr_a_i),
        .rd_i   (rd_cmd),
        .dout_o (dout_a)
    );

    master_trig_uram u_store_b (
        .clk_i  (clk_i),
        .wr_i   (wr_b_i),
        .rd_i   (rd_cmd),
        .dout_o (dout_b)
    );

    // one controller for both halves keeps their slots aligned.
    l2_readout_ctrl u_ctrl (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .start_i   (start_i),
        .rd_addr_i (rd_addr_i),
        .busy_o    (busy_o),
        .rd_o      (rd_cmd),
        .addr_o    (rd_addr_q),
        .issued_o  (issued)
    );

    l2_trig_combiner u_combiner (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .issued_i    (issued),
        .addr_i      (rd_addr_q),
        .dout_a_i    (dout_a),
        .dout_b_i    (dout_b),
        .mask_i      (mask_i),
        .threshold_i (threshold_i),
        .result_o    (result_o)
    );

endmodule

// ==== design/master_trig_uram.sv ====
`timescale 1ns/100ps
// behavioural model of one trigger metadata store.
// the real part is an UltraRAM in parity-interleaved byte-write mode, so each byte-write
// enable also covers one of the eight parity bits, and those bits hold the triggers.
module master_trig_uram (
    input  logic                        clk_i,
    // port A writes metadata bytes and sets trigger bits.
    input  trig_types_pkg::trig_wr_t    wr_i,
    // port B reads a slot and clears it on the following command.
    input  trig_types_pkg::store_rd_t   rd_i,
    output trig_types_pkg::store_dout_t dout_o
);

    import trig_cfg_pkg::*;
    import trig_types_pkg::*;

    // the array starts out empty, just like the URAM after configuration.
    // a clear is the only thing that empties a slot again.
    store_dout_t mem [DEPTH] = '{default: '0};

    // read register of port B.
    // it only changes on a read, so a clear leaves the last read word in place.
    store_dout_t dout_q;

    // both ports share one clock, so they are modelled in one process.
    // port A comes first and the port B clear comes last, which lets the clear win
    // when both hit the same slot in the same cycle.
    always_ff @(posedge clk_i) begin
        if (wr_i.wr_en) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                if (wr_i.we[l]) begin
                    // the data input of the parity position is tied high in the
                    // real design, so a byte write always sets the trigger bit.
                    mem[wr_i.waddr].metadata[l*LANE_W +: LANE_W] <=
                        wr_i.metadata[l*LANE_W +: LANE_W];
                    mem[wr_i.waddr].trigger[l] <= 1'b1;
                end
            end
        end
        if (rd_i.rd_en) begin
            if (rd_i.rd_phase) begin
                // clear phase writes zeros with every byte enable set.
                // the word is wiped, parity and trigger bits included.
                mem[rd_i.raddr] <= '0;
            end else begin
                dout_q <= mem[rd_i.raddr];
            end
        end
    end

    assign dout_o = dout_q;

endmodule

// ==== design/trig_cfg_pkg.sv ====
// sizing constants shared by the stores, the readout controller and the combiner.
package trig_cfg_pkg;

    // one trigger lane per detector channel in a half.
    // each lane owns one byte lane of the metadata store.
    localparam int NUM_LANES = 8;

    // metadata slice carried for one lane.
    localparam int LANE_W = 8;

    // full metadata word of one store, eight bytes side by side.
    // together with the eight parity-position trigger bits this fills a 72-bit URAM word.
    localparam int META_W = NUM_LANES * LANE_W;

    // a store address selects one time slot.
    localparam int ADDR_W = 12;

    // number of time slots, which is the full address space of one URAM.
    localparam int DEPTH = 1 << ADDR_W;

    // width of the trigger-bit count over both halves.
    // sixteen lanes at most, so five bits are enough.
    localparam int CNT_W = 5;

endpackage

// ==== design/trig_types_pkg.sv ====
// bundles that travel between the stores, the readout controller and the combiner.
package trig_types_pkg;

    import trig_cfg_pkg::*;

    // one port-A write into a store.
    // every set bit of we writes that lane's metadata byte and sets its trigger bit.
    typedef struct packed {
        logic                 wr_en;
        logic [ADDR_W-1:0]    waddr;
        logic [META_W-1:0]    metadata;
        logic [NUM_LANES-1:0] we;
    } trig_wr_t;

    // port-B command to a store.
    // rd_phase low reads the slot, rd_phase high clears it.
    typedef struct packed {
        logic              rd_en;
        logic              rd_phase;
        logic [ADDR_W-1:0] raddr;
    } store_rd_t;

    // one 72-bit store word as seen on the read port.
    // the trigger bits sit where the parity bits of the URAM would be.
    typedef struct packed {
        logic [META_W-1:0]    metadata;
        logic [NUM_LANES-1:0] trigger;
    } store_dout_t;

    // one finished readout of a time slot from both halves.
    // trig and meta fields are already masked, hit_count counts the masked bits.
    typedef struct packed {
        logic                 valid;
        logic [ADDR_W-1:0]    addr;
        logic [NUM_LANES-1:0] trig_a;
        logic [NUM_LANES-1:0] trig_b;
        logic [META_W-1:0]    meta_a;
        logic [META_W-1:0]    meta_b;
        logic [CNT_W-1:0]     hit_count;
        logic                 accept;
    } l2_result_t;

    // readout sequence: a read cycle and then a clear cycle.
    typedef enum logic [1:0] {
        IDLE,
        READ,
        CLEAR
    } readout_state_e;

endpackage

// ==== master_trig_l2.f ====
design/trig_cfg_pkg.sv
design/trig_types_pkg.sv
design/master_trig_uram.sv
design/l2_readout_ctrl.sv
design/l2_trig_combiner.sv
design/master_trig_l2.sv
sim/tb_master_trig_l2.sv

// ==== sim/tb_master_trig_l2.sv ====
`timescale 1ns/100ps
// table-driven testbench for the readout half of the master trigger.
// a shadow copy of each store predicts what every readout has to return.
module tb_master_trig_l2;

    import trig_cfg_pkg::*;
    import trig_types_pkg::*;

    // what one table row does to the DUT.
    typedef enum logic [1:0] {
        WRITE_A,
        WRITE_B,
        READOUT
    } stim_kind_e;

    // one row of stimulus.
    // poke keeps start_i high while the controller is still busy with this readout.
    typedef struct packed {
        stim_kind_e             kind;
        logic [ADDR_W-1:0]      addr;
        logic [NUM_LANES-1:0]   we;
        logic [2*NUM_LANES-1:0] mask;
        logic [CNT_W-1:0]       threshold;
        logic                   poke;
    } stim_t;

    logic                   clk_i;
    logic                   reset_i;
    trig_wr_t               wr_a_i;
    trig_wr_t               wr_b_i;
    logic                   start_i;
    logic [ADDR_W-1:0]      rd_addr_i;
    logic [2*NUM_LANES-1:0] mask_i;
    logic [CNT_W-1:0]       threshold_i;
    logic                   busy_o;
    l2_result_t             result_o;

    // the table, with the test names kept alongside.
    stim_t                  stim_q[$];
    string                  name_q[$];

    // shadow stores that follow the write and clear rules of the metadata store.
    store_dout_t            shadow_a [DEPTH];
    store_dout_t            shadow_b [DEPTH];

    int                     cycle;
    int                     watchdog_cycles;
    int                     cycle_limit = 1000;
    string                  cur_name;

    // one predicted result waits for its cycle, and so does the clear behind it.
    logic                   exp_pending;
    int                     exp_due;
    l2_result_t             exp_word;
    string                  exp_name;
    logic                   clear_pending;
    int                     clear_due;
    logic [ADDR_W-1:0]      clear_addr;

    master_trig_l2 i_dut (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .wr_a_i      (wr_a_i),
        .wr_b_i      (wr_b_i),
        .start_i     (start_i),
        .rd_addr_i   (rd_addr_i),
        .mask_i      (mask_i),
        .threshold_i (threshold_i),
        .busy_o      (busy_o),
        .result_o    (result_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    task automatic end_with_failure();
        $display("test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    // the run is bounded by the length of the table.
    always @(posedge clk_i) begin
        watchdog_cycles++;
        if (watchdog_cycles > cycle_limit) begin
            $display("timeout: the run went past %0d clock cycles", cycle_limit);
            end_with_failure();
        end
    end

    // an expected word with valid low means no readout is due.
    // then only valid is compared, since the other fields just hold.
    task automatic check_result(input string name, input l2_result_t exp,
                                input l2_result_t act);
        logic bad;
        if (exp.valid) begin
            bad = (act !== exp);
        end else begin
            bad = (act.valid !== 1'b0);
        end
        if (bad) begin
            $display("MISMATCH %s result: expected %h, actual %h", name, exp, act);
            end_with_failure();
        end
    endtask

    task automatic check_busy(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %s busy: expected %b, actual %b", name, exp, act);
            end_with_failure();
        end
    endtask

    task automatic add_entry(
        input stim_kind_e             kind,
        input logic [ADDR_W-1:0]      addr,
        input logic [NUM_LANES-1:0]   we,
        input logic [2*NUM_LANES-1:0] mask,
        input logic [CNT_W-1:0]       threshold,
        input logic                   poke,
        input string                  name
    );
        stim_t s;
        s.kind      = kind;
        s.addr      = addr;
        s.we        = we;
        s.mask      = mask;
        s.threshold = threshold;
        s.poke      = poke;
        stim_q.push_back(s);
        name_q.push_back(name);
    endtask

    task automatic build_table();
        // a slot that was never written reads back empty.
        add_entry(READOUT, 12'h005, 8'h00, 16'hffff, 5'd1, 1'b0, "rd_unwritten_slot");
        // sparse lanes first, then more lanes and one byte written again.
        add_entry(WRITE_A, 12'h010, 8'h05, 16'hffff, 5'd0, 1'b0, "wr_a_sparse");
        add_entry(WRITE_A, 12'h010, 8'h80, 16'hffff, 5'd0, 1'b0, "wr_a_merge");
        add_entry(WRITE_A, 12'h010, 8'h04, 16'hffff, 5'd0, 1'b0, "wr_a_rewrite_lane");
        add_entry(READOUT, 12'h010, 8'h00, 16'hffff, 5'd3, 1'b0, "rd_a_merged");
        // started at the earliest edge, it has to find the slot cleared.
        add_entry(READOUT, 12'h010, 8'h00, 16'hffff, 5'd0, 1'b0, "rd_a_after_clear");
        add_entry(WRITE_A, 12'h020, 8'h0f, 16'hffff, 5'd0, 1'b0, "wr_a_low_lanes");
        add_entry(WRITE_B, 12'h020, 8'hf0, 16'hffff, 5'd0, 1'b0, "wr_b_high_lanes");
        add_entry(WRITE_B, 12'h021, 8'hff, 16'hffff, 5'd0, 1'b0, "wr_b_full_word");
        add_entry(READOUT, 12'h020, 8'h00, 16'hffff, 5'd8, 1'b0, "rd_both_halves");
        add_entry(READOUT, 12'h021, 8'h00, 16'hffff, 5'd9, 1'b0, "rd_b_below_threshold");
        add_entry(WRITE_A, 12'h030, 8'hff, 16'hffff, 5'd0, 1'b0, "wr_a_for_mask");
        add_entry(WRITE_B, 12'h030, 8'hff, 16'hffff, 5'd0, 1'b0, "wr_b_for_mask");
        add_entry(READOUT, 12'h030, 8'h00, 16'h0f3c, 5'd6, 1'b0, "rd_masked_accept");
        add_entry(WRITE_A, 12'h031, 8'haa, 16'hffff, 5'd0, 1'b0, "wr_a_odd_lanes");
        add_entry(WRITE_B, 12'h031, 8'h55, 16'hffff, 5'd0, 1'b0, "wr_b_even_lanes");
        add_entry(READOUT, 12'h031, 8'h00, 16'h00ff, 5'd5, 1'b0, "rd_masked_reject");
        add_entry(WRITE_A, 12'h040, 8'h33, 16'hffff, 5'd0, 1'b0, "wr_a_before_poke");
        add_entry(READOUT, 12'h040, 8'h00, 16'hffff, 5'd2, 1'b1, "rd_start_while_busy");
        // this write lands on the same edge as the clear of slot 0x040.
        add_entry(WRITE_A, 12'h040, 8'h0c, 16'hffff, 5'd0, 1'b0, "wr_a_on_clear_edge");
        add_entry(READOUT, 12'h040, 8'h00, 16'hffff, 5'd1, 1'b0, "rd_clear_beat_write");
        add_entry(WRITE_B, 12'hfff, 8'h81, 16'hffff, 5'd0, 1'b0, "wr_b_top_slot");
        add_entry(READOUT, 12'hfff, 8'h00, 16'h8000, 5'd1, 1'b0, "rd_top_slot_one_lane");
    endtask

    // every enabled lane takes its byte and gets its trigger bit set.
    function automatic store_dout_t merge_write(input store_dout_t old, input trig_wr_t w);
        store_dout_t word;
        word = old;
        for (int l = 0; l < NUM_LANES; l++) begin
            if (w.we[l]) begin
                word.metadata[l*LANE_W +: LANE_W] = w.metadata[l*LANE_W +: LANE_W];
                word.trigger[l] = 1'b1;
            end
        end
        return word;
    endfunction

    // expected readout of a slot, taken from the shadow stores.
    function automatic l2_result_t predict_readout(
        input logic [ADDR_W-1:0]      addr,
        input logic [2*NUM_LANES-1:0] mask,
        input logic [CNT_W-1:0]       threshold
    );
        l2_result_t r;
        int         hits;
        r       = '0;
        hits    = 0;
        r.valid = 1'b1;
        r.addr  = addr;
        for (int l = 0; l < NUM_LANES; l++) begin
            if (mask[l]) begin
                r.trig_a[l] = shadow_a[addr].trigger[l];
                r.meta_a[l*LANE_W +: LANE_W] = shadow_a[addr].metadata[l*LANE_W +: LANE_W];
            end
            if (mask[NUM_LANES+l]) begin
                r.trig_b[l] = shadow_b[addr].trigger[l];
                r.meta_b[l*LANE_W +: LANE_W] = shadow_b[addr].metadata[l*LANE_W +: LANE_W];
            end
            hits = hits + int'(r.trig_a[l]) + int'(r.trig_b[l]);
        end
        r.hit_count = CNT_W'(hits);
        r.accept    = (hits >= int'(threshold));
        return r;
    endfunction

    // one clock cycle, with the result checked on every cycle.
    // outside a due readout valid has to stay low.
    task automatic step_cycle();
        l2_result_t idle_word;
        idle_word = '0;
        @(posedge clk_i);
        #1;
        cycle++;
        // a write sampled on this edge was already in the shadow, so the clear wins.
        if (clear_pending && clear_due == cycle) begin
            shadow_a[clear_addr] = '0;
            shadow_b[clear_addr] = '0;
            clear_pending = 1'b0;
        end
        if (exp_pending && exp_due == cycle) begin
            check_result(exp_name, exp_word, result_o);
            exp_pending = 1'b0;
        end else begin
            check_result(cur_name, idle_word, result_o);
        end
    endtask

    task automatic do_write(input stim_t s);
        trig_wr_t w;
        w.wr_en    = 1'b1;
        w.waddr    = s.addr;
        w.metadata = {$urandom, $urandom};
        w.we       = s.we;
        if (s.kind == WRITE_A) begin
            shadow_a[s.addr] = merge_write(shadow_a[s.addr], w);
            wr_a_i = w;
        end else begin
            shadow_b[s.addr] = merge_write(shadow_b[s.addr], w);
            wr_b_i = w;
        end
        step_cycle();
        wr_a_i.wr_en = 1'b0;
        wr_b_i.wr_en = 1'b0;
        check_busy(cur_name, 1'b0, busy_o);
    endtask

    // the strobe is taken at edge 0, the read lands at edge 2, the clear at edge 3.
    // the mask is driven after edge 0 so the previous readout still sees its own.
    task automatic do_readout(input stim_t s);
        int start_cycle;
        start_i   = 1'b1;
        rd_addr_i = s.addr;
        step_cycle();
        start_cycle = cycle;
        check_busy(cur_name, 1'b1, busy_o);
        // a poke strobes again for another slot while the sequence is running.
        start_i     = s.poke;
        rd_addr_i   = s.addr ^ ADDR_W'(1);
        mask_i      = s.mask;
        threshold_i = s.threshold;
        step_cycle();
        check_busy(cur_name, 1'b1, busy_o);
        exp_word    = predict_readout(s.addr, s.mask, s.threshold);
        exp_due     = start_cycle + 3;
        exp_name    = cur_name;
        exp_pending = 1'b1;
        step_cycle();
        check_busy(cur_name, 1'b0, busy_o);
        start_i       = 1'b0;
        clear_addr    = s.addr;
        clear_due     = start_cycle + 3;
        clear_pending = 1'b1;
    endtask

    initial begin : main_seq
        int    seed_word;
        stim_t s;
        seed_word       = $urandom(10833);
        reset_i         = 1'b1;
        wr_a_i          = '0;
        wr_b_i          = '0;
        start_i         = 1'b0;
        rd_addr_i       = '0;
        mask_i          = '1;
        threshold_i     = '0;
        cycle           = 0;
        watchdog_cycles = 0;
        exp_pending     = 1'b0;
        clear_pending   = 1'b0;
        for (int a = 0; a < DEPTH; a++) begin
            shadow_a[a] = '0;
            shadow_b[a] = '0;
        end
        build_table();
        cycle_limit = 8 * stim_q.size() + 200;
        repeat (16) @(posedge clk_i);
        #1;
        reset_i  = 1'b0;
        cur_name = "after_reset";
        check_busy(cur_name, 1'b0, busy_o);
        check_result(cur_name, '0, result_o);
        for (int i = 0; i < stim_q.size(); i++) begin
            s        = stim_q[i];
            cur_name = name_q[i];
            if (s.kind == READOUT) begin
                do_readout(s);
            end else begin
                do_write(s);
            end
        end
        // the last result comes out here, and no stray valid may follow it.
        cur_name = "drain";
        repeat (4) step_cycle();
        if (exp_pending) begin
            $display("the last readout never produced its result");
            end_with_failure();
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule
